// File: src/video_mode_pkg.sv
package video_mode_pkg;

	typedef logic [10:0] coord_t;     // Pixel or line position, also thresholds
	typedef logic [3:0]  mode_code_t; // Raw switch code
	typedef logic [7:0]  clkgen_t;    // Synthesizer factor, stored minus one

	////////////////////
	// Switch codes
	////////////////////

	localparam mode_code_t MODE_VGA    = 4'b0000;
	localparam mode_code_t MODE_SVGA   = 4'b0001;
	localparam mode_code_t MODE_XGA    = 4'b0011;
	localparam mode_code_t MODE_HD720  = 4'b0010;
	localparam mode_code_t MODE_SXGA   = 4'b1000;
	localparam mode_code_t MODE_CAMERA = 4'b1001;

	////////////////////
	// Timing records
	////////////////////

	// One display format, porches and sync widths in pixels or lines
	typedef struct packed {
		coord_t hpixels; // Live pixels
		coord_t hfporch;
		coord_t hsync_w;
		coord_t hbporch;
		coord_t vlines;  // Live lines
		coord_t vfporch;
		coord_t vsync_w;
		coord_t vbporch;
		logic   neg_pol; // Sync active low
	} format_t;

	// Cumulative counter thresholds
	typedef struct packed {
		coord_t hsblnk; // Last live pixel
		coord_t hssync;
		coord_t hesync;
		coord_t heblnk; // Last pixel of the line
		coord_t vsblnk;
		coord_t vssync;
		coord_t vesync;
		coord_t veblnk;
	} thresholds_t;

	// Format table, unknown codes fall back to 720p
	function automatic format_t format_of(input mode_code_t code);
		format_t fmt;
		case (code)
			MODE_VGA: // 640x480, negative sync
				fmt = '{11'd640, 11'd16, 11'd96, 11'd48,
					11'd480, 11'd11, 11'd2, 11'd31, 1'b1};
			MODE_SVGA: // 800x600
				fmt = '{11'd800, 11'd40, 11'd128, 11'd88,
					11'd600, 11'd1, 11'd4, 11'd23, 1'b0};
			MODE_XGA: // 1024x768, negative sync
				fmt = '{11'd1024, 11'd24, 11'd136, 11'd160,
					11'd768, 11'd3, 11'd6, 11'd29, 1'b1};
			MODE_SXGA: // 1280x1024
				fmt = '{11'd1280, 11'd48, 11'd112, 11'd248,
					11'd1024, 11'd1, 11'd3, 11'd38, 1'b0};
			MODE_CAMERA: // 720 lines, one pixel shorter hsync than 720p
				fmt = '{11'd1280, 11'd110, 11'd39, 11'd220,
					11'd720, 11'd4, 11'd4, 11'd22, 1'b0};
			default: // 1280x720
				fmt = '{11'd1280, 11'd110, 11'd40, 11'd220,
					11'd720, 11'd5, 11'd5, 11'd20, 1'b0};
		endcase
		return fmt;
	endfunction

endpackage

// File: src/video_if.sv
// Timing setup from the mode table to the raster and output stages
interface timing_cfg_if;
	import video_mode_pkg::*;

	thresholds_t thresholds; // Registered per mode
	logic        neg_polarity;
	logic        restart;    // One cycle, raster back to 0,0

	modport cfg_src (
		output thresholds,
		output neg_polarity,
		output restart
	);

	modport cfg_raster (
		input thresholds,
		input restart
	);

	// Output stage only needs the polarity
	modport cfg_sync (
		input neg_polarity
	);
endinterface

// Raster position and raw decodes
interface raster_if;
	import video_mode_pkg::*;

	coord_t hcount;
	coord_t vcount;
	logic   hsync_int; // Active high, before polarity
	logic   vsync_int;
	logic   hblnk;
	logic   vblnk;

	modport raster_src (
		output hcount,
		output vcount,
		output hsync_int,
		output vsync_int,
		output hblnk,
		output vblnk
	);

	modport raster_sink (
		input hsync_int,
		input vsync_int,
		input hblnk,
		input vblnk
	);
endinterface

// File: src/switch_debouncer.sv
module switch_debouncer #(
	parameter int DEBOUNCE_CYCLES = 65536 // Cycles a new code must hold
) (
	input  logic                       clk50m_bufg,
	input  logic                       arst_n,
	input  video_mode_pkg::mode_code_t sw,
	output video_mode_pkg::mode_code_t mode_code,
	output logic                       mode_change
);
	import video_mode_pkg::*;

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES);

	mode_code_t       sw_meta;    // First sync flop
	mode_code_t       sw_sync;    // Second sync flop
	mode_code_t       sw_last;    // Previous synced code, for movement
	logic [CNT_W-1:0] stable_cnt; // Cycles without movement
	logic             sw_moved;
	logic             accept;

	assign sw_moved = (sw_sync != sw_last);

	// Held long enough and not the code already in use
	assign accept = !sw_moved && (stable_cnt == CNT_MAX) && (sw_sync != mode_code);

	////////////////////
	// Sync and filter
	////////////////////

	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			sw_meta     <= MODE_VGA;
			sw_sync     <= MODE_VGA;
			sw_last     <= MODE_VGA;
			stable_cnt  <= '0;
			mode_code   <= MODE_VGA; // Power up in VGA
			mode_change <= 1'b0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_last <= sw_sync;

			// Any bounce restarts the count
			if (sw_moved)
				stable_cnt <= '0;
			else if (stable_cnt != CNT_MAX)
				stable_cnt <= stable_cnt + CNT_W'(1); // saturates

			mode_change <= accept; // Single cycle strobe
			if (accept)
				mode_code <= sw_sync;
		end
	end

endmodule

// File: src/mode_table.sv
module mode_table (
	input  logic                       clk50m_bufg,
	input  logic                       arst_n,
	input  video_mode_pkg::mode_code_t mode_code,
	input  logic                       mode_change,
	output video_mode_pkg::clkgen_t    pclk_m,
	output video_mode_pkg::clkgen_t    pclk_d,
	output video_mode_pkg::mode_code_t mode,
	timing_cfg_if.cfg_src              cfg
);
	import video_mode_pkg::*;

	// Turns porches and widths into running counter thresholds
	function automatic thresholds_t derive_thr(input format_t f);
		thresholds_t t;
		t.hsblnk = f.hpixels - 11'd1;
		t.hssync = t.hsblnk + f.hfporch;
		t.hesync = t.hssync + f.hsync_w;
		t.heblnk = t.hesync + f.hbporch;
		t.vsblnk = f.vlines - 11'd1;
		t.vssync = t.vsblnk + f.vfporch;
		t.vesync = t.vssync + f.vsync_w;
		t.veblnk = t.vesync + f.vbporch;
		return t;
	endfunction

	localparam format_t     VGA_FMT = format_of(MODE_VGA);
	localparam thresholds_t VGA_THR = derive_thr(VGA_FMT);

	format_t fmt;   // Format of the incoming code
	clkgen_t m_sel; // M minus one
	clkgen_t d_sel; // D minus one

	assign fmt = format_of(mode_code);

	////////////////////
	// Synthesizer M/D
	////////////////////

	always_comb begin
		case (mode_code)
			MODE_VGA: begin // 25 MHz
				m_sel = 8'd2 - 8'd1;
				d_sel = 8'd4 - 8'd1;
			end
			MODE_SVGA: begin // 40 MHz
				m_sel = 8'd4 - 8'd1;
				d_sel = 8'd5 - 8'd1;
			end
			MODE_XGA: begin // 65 MHz
				m_sel = 8'd13 - 8'd1;
				d_sel = 8'd10 - 8'd1;
			end
			MODE_SXGA: begin // 108 MHz
				m_sel = 8'd54 - 8'd1;
				d_sel = 8'd25 - 8'd1;
			end
			MODE_CAMERA: begin
				m_sel = 8'd135 - 8'd1;
				d_sel = 8'd91 - 8'd1;
			end
			default: begin // 74.25 MHz, 720p
				m_sel = 8'd248 - 8'd1;
				d_sel = 8'd167 - 8'd1;
			end
		endcase
	end

	// Everything loads together with the restart strobe
	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			cfg.thresholds   <= VGA_THR;
			cfg.neg_polarity <= VGA_FMT.neg_pol;
			cfg.restart      <= 1'b0;
			pclk_m           <= 8'd2 - 8'd1;
			pclk_d           <= 8'd4 - 8'd1;
			mode             <= MODE_VGA;
		end else begin
			cfg.restart <= mode_change;
			if (mode_change) begin
				cfg.thresholds   <= derive_thr(fmt);
				cfg.neg_polarity <= fmt.neg_pol;
				pclk_m           <= m_sel;
				pclk_d           <= d_sel;
				mode             <= mode_code;
			end
		end
	end

endmodule

// File: src/raster_counter.sv
module raster_counter (
	input  logic             clk50m_bufg,
	input  logic             arst_n,
	timing_cfg_if.cfg_raster cfg,
	raster_if.raster_src     rst
);
	import video_mode_pkg::*;

	thresholds_t thr;   // Short local name for the thresholds
	logic        h_end; // Last pixel of the line
	logic        v_end; // Last line of the frame

	assign thr = cfg.thresholds;

	assign h_end = (rst.hcount == thr.heblnk);
	assign v_end = (rst.vcount == thr.veblnk);

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			rst.hcount <= '0;
			rst.vcount <= '0;
		end else if (cfg.restart) begin
			// New mode starts from the top left corner
			rst.hcount <= '0;
			rst.vcount <= '0;
		end else if (h_end) begin
			rst.hcount <= '0; // Wrap line
			if (v_end)
				rst.vcount <= '0; // Wrap frame
			else
				rst.vcount <= rst.vcount + 11'd1;
		end else begin
			rst.hcount <= rst.hcount + 11'd1;
		end
	end

	////////////////////
	// Decodes
	////////////////////

	// Blanking past the live area
	assign rst.hblnk = (rst.hcount > thr.hsblnk);
	assign rst.vblnk = (rst.vcount > thr.vsblnk);

	// Sync window (start, end], still active high here
	assign rst.hsync_int = (rst.hcount > thr.hssync) && (rst.hcount <= thr.hesync);
	assign rst.vsync_int = (rst.vcount > thr.vssync) && (rst.vcount <= thr.vesync);

endmodule

// File: src/sync_output.sv
module sync_output (
	input  logic            clk50m_bufg,
	input  logic            arst_n,
	raster_if.raster_sink   rst,
	timing_cfg_if.cfg_sync  cfg,
	output logic            hsync,
	output logic            vsync,
	output logic            de
);

	logic hsync_q;  // Stage 1, polarity applied
	logic vsync_q;
	logic active_q; // Stage 1, inside both live areas

	////////////////////
	// Two stage delay
	////////////////////

	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			hsync_q  <= 1'b1; // Idle high for VGA
			vsync_q  <= 1'b1;
			active_q <= 1'b0;
			hsync    <= 1'b1;
			vsync    <= 1'b1;
			de       <= 1'b0;
		end else begin
			hsync_q  <= rst.hsync_int ^ cfg.neg_polarity;
			vsync_q  <= rst.vsync_int ^ cfg.neg_polarity;
			active_q <= !rst.hblnk && !rst.vblnk;
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			de       <= active_q; // data enable
		end
	end

endmodule

// File: src/video_timing_top.sv
module video_timing_top #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  logic                       clk50m_bufg,
	input  logic                       arst_n,
	input  video_mode_pkg::mode_code_t sw,     // Mode switches, asynchronous
	output logic                       hsync,
	output logic                       vsync,
	output logic                       de,
	output video_mode_pkg::clkgen_t    pclk_m, // To the pixel clock synthesizer
	output video_mode_pkg::clkgen_t    pclk_d,
	output video_mode_pkg::mode_code_t mode
);
	import video_mode_pkg::*;

	mode_code_t deb_code;   // Accepted switch code
	logic       deb_change; // Pulses when the code is accepted

	timing_cfg_if cfg_if ();
	raster_if     rst_if ();

	////////////////////
	// Pipeline
	////////////////////

	switch_debouncer #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) debounce_i (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.sw          (sw),
		.mode_code   (deb_code),
		.mode_change (deb_change)
	);

	mode_table mode_table_i (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.mode_code   (deb_code),
		.mode_change (deb_change),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.mode        (mode),
		.cfg         (cfg_if.cfg_src)
	);

	raster_counter raster_i (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.cfg         (cfg_if.cfg_raster),
		.rst         (rst_if.raster_src)
	);

	// Final sync and data enable, two cycles behind the raster
	sync_output sync_i (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.rst         (rst_if.raster_sink),
		.cfg         (cfg_if.cfg_sync),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule

// File: tests/video_ref.svh
`ifndef VIDEO_REF_SVH
`define VIDEO_REF_SVH

// Switch codes as seen on sw and mode
localparam logic [3:0] CODE_VGA    = 4'b0000;
localparam logic [3:0] CODE_SVGA   = 4'b0001;
localparam logic [3:0] CODE_XGA    = 4'b0011;
localparam logic [3:0] CODE_HD720  = 4'b0010;
localparam logic [3:0] CODE_SXGA   = 4'b1000;
localparam logic [3:0] CODE_CAMERA = 4'b1001;
localparam logic [3:0] CODE_UNDEF  = 4'b0111; // Not in the table, runs as 720p

////////////////////
// Format table
////////////////////

typedef struct {
	int         hpix; // Live pixels
	int         hfp;
	int         hsw;
	int         hbp;
	int         vlin; // Live lines
	int         vfp;
	int         vsw;
	int         vbp;
	logic       neg;  // Sync active low
	logic [7:0] m;    // Synthesizer factors, not minus one
	logic [7:0] d;
} ref_fmt_t;

function automatic ref_fmt_t ref_format(input logic [3:0] code);
	ref_fmt_t f;
	case (code)
		CODE_VGA:    f = '{640, 16, 96, 48, 480, 11, 2, 31, 1'b1, 8'd2, 8'd4};
		CODE_SVGA:   f = '{800, 40, 128, 88, 600, 1, 4, 23, 1'b0, 8'd4, 8'd5};
		CODE_XGA:    f = '{1024, 24, 136, 160, 768, 3, 6, 29, 1'b1, 8'd13, 8'd10};
		CODE_SXGA:   f = '{1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0, 8'd54, 8'd25};
		CODE_CAMERA: f = '{1280, 110, 39, 220, 720, 4, 4, 22, 1'b0, 8'd135, 8'd91};
		default:     f = '{1280, 110, 40, 220, 720, 5, 5, 20, 1'b0, 8'd248, 8'd167};
	endcase
	return f;
endfunction

////////////////////
// Expected measurements
////////////////////

function automatic int line_cycles(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.hpix + f.hfp + f.hsw + f.hbp; // Whole line, blanking included
endfunction

function automatic int hsync_cycles(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.hsw;
endfunction

function automatic int de_cycles(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.hpix;
endfunction

function automatic int frame_lines(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.vlin + f.vfp + f.vsw + f.vbp;
endfunction

// Inactive sync level, high for negative polarity
function automatic logic idle_level(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.neg;
endfunction

// Register values on pclk_m and pclk_d
function automatic logic [7:0] m_reg(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.m - 8'd1;
endfunction

function automatic logic [7:0] d_reg(input logic [3:0] code);
	ref_fmt_t f = ref_format(code);
	return f.d - 8'd1;
endfunction

// Bounce hold times
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: tests/tb_video_timing.sv
module tb_video_timing;
	timeunit 1ns;
	timeprecision 1ps;

	`include "video_ref.svh"

	localparam int MODE_WAIT  = 200;     // Sync, debounce and table load
	localparam int LINE_WAIT  = 12000;   // A few of the longest lines
	localparam int FRAME_WAIT = 1000000; // Two VGA frames plus margin

	logic       clk50m_bufg = 1'b0;
	logic       arst_n;
	logic [3:0] sw;
	logic       hsync;
	logic       vsync;
	logic       de;
	logic [7:0] pclk_m;
	logic [7:0] pclk_d;
	logic [3:0] mode;

	logic [3:0]  exp_code = CODE_VGA; // Format the measurer expects
	logic        meas_en = 1'b0;
	logic [31:0] lcg_state;
	logic [3:0]  seq_codes [7] = '{CODE_SVGA, CODE_XGA, CODE_HD720, CODE_SXGA,
		CODE_CAMERA, CODE_UNDEF, CODE_VGA}; // VGA last, ready for bounce
	int          chk_errs = 0;  // Main flow
	int          meas_errs = 0; // Measuring process
	int          tmo_errs = 0;
	int          n_line = 0;    // Completed checks since enable
	int          n_width = 0;
	int          n_de = 0;
	int          n_frame = 0;

	video_timing_top #(
		.DEBOUNCE_CYCLES (16)
	) dut_i (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.mode        (mode)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk50m_bufg);
		arst_n <= 1'b1;
	end

	task automatic check_value(input string name, input int got, input int want,
		inout int errs);
		assert (got == want) else begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, want);
			errs++;
		end
	endtask

	////////////////////
	// Measuring process
	////////////////////

	int   cyc = 0;
	int   h_start = -1; // Cycle of last active edge, -1 none yet
	int   v_start = -1;
	int   de_start = -1;
	logic h_act;
	logic v_act;
	logic h_act_q = 1'b0;
	logic v_act_q = 1'b0;
	logic de_q = 1'b0;

	always @(negedge clk50m_bufg) begin
		cyc++;
		h_act = (hsync != idle_level(exp_code));
		v_act = (vsync != idle_level(exp_code));
		if (!arst_n || !meas_en) begin
			h_start  = -1; // Forget partial runs
			v_start  = -1;
			de_start = -1;
			n_line   = 0;
			n_width  = 0;
			n_de     = 0;
			n_frame  = 0;
		end else begin
			if (h_act && !h_act_q) begin // Leading hsync edge
				if (h_start >= 0) begin
					check_value("hsync period", cyc - h_start, line_cycles(exp_code),
						meas_errs);
					n_line++;
				end
				h_start = cyc;
			end
			if (!h_act && h_act_q && h_start >= 0) begin
				check_value("hsync width", cyc - h_start, hsync_cycles(exp_code), meas_errs);
				n_width++;
			end
			if (de && !de_q)
				de_start = cyc;
			if (!de && de_q && de_start >= 0) begin
				check_value("de run", cyc - de_start, de_cycles(exp_code), meas_errs);
				n_de++;
			end
			if (v_act && !v_act_q) begin
				if (v_start >= 0) begin
					check_value("vsync period", cyc - v_start,
						frame_lines(exp_code) * line_cycles(exp_code), meas_errs);
					n_frame++;
				end
				v_start = cyc;
			end
		end
		h_act_q = h_act;
		v_act_q = v_act;
		de_q    = de;
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	task automatic wait_counts(input int n, input int frames, input int limit);
		int t;
		bit done;
		done = 1'b0;
		for (t = 0; t < limit && !done; t++) begin
			@(posedge clk50m_bufg);
			done = (n_line >= n) && (n_width >= n) && (n_de >= n) && (n_frame >= frames);
		end
		if (!done) begin
			$display("Timeout: line or frame measurements incomplete after %0d cycles", limit);
			tmo_errs++;
		end
	endtask

	// Switch to a code, check factors, idle sync and the following lines
	task automatic change_mode(input logic [3:0] code);
		int t;
		bit done;
		meas_en <= 1'b0;
		@(posedge clk50m_bufg);
		sw <= code;
		done = 1'b0;
		for (t = 0; t < MODE_WAIT && !done; t++) begin
			@(negedge clk50m_bufg);
			done = (mode == code);
		end
		if (!done) begin
			$display("Timeout: mode did not switch to %b within %0d cycles", code, MODE_WAIT);
			tmo_errs++;
		end
		check_value("pclk_m", int'(pclk_m), int'(m_reg(code)), chk_errs);
		check_value("pclk_d", int'(pclk_d), int'(d_reg(code)), chk_errs);
		repeat (3) @(negedge clk50m_bufg); // Position 0,0 reaches the pins
		check_value("hsync", int'(hsync), int'(idle_level(code)), chk_errs);
		check_value("vsync", int'(vsync), int'(idle_level(code)), chk_errs);
		exp_code <= code;
		meas_en  <= 1'b1;
		wait_counts(2, 0, LINE_WAIT);
	endtask

	// Short holds only, the accepted code must not move
	task automatic bounce(input logic [3:0] code, input logic [3:0] home);
		int hold;
		int i;
		int k;
		meas_en <= 1'b0;
		for (i = 0; i < 24; i++) begin
			lcg_state = lcg_next(lcg_state);
			hold = int'(lcg_state >> 16) % 14 + 1; // 1 to 14 cycles
			@(posedge clk50m_bufg);
			sw <= (i % 2 == 0) ? code : home;
			for (k = 0; k < hold; k++) begin
				@(negedge clk50m_bufg);
				check_value("mode", int'(mode), int'(home), chk_errs);
				check_value("pclk_m", int'(pclk_m), int'(m_reg(home)), chk_errs);
			end
		end
	endtask

	initial begin
		sw        = CODE_VGA;
		lcg_state = 32'hc9be_5660;
		// Two samples in reset, two after release
		repeat (4) begin
			@(negedge clk50m_bufg);
			check_value("de", int'(de), 0, chk_errs);
			check_value("hsync", int'(hsync), int'(idle_level(CODE_VGA)), chk_errs);
			check_value("vsync", int'(vsync), int'(idle_level(CODE_VGA)), chk_errs);
			check_value("pclk_m", int'(pclk_m), int'(m_reg(CODE_VGA)), chk_errs);
			check_value("pclk_d", int'(pclk_d), int'(d_reg(CODE_VGA)), chk_errs);
			check_value("mode", int'(mode), int'(CODE_VGA), chk_errs);
		end

		// VGA lines and one whole frame
		exp_code <= CODE_VGA;
		meas_en  <= 1'b1;
		wait_counts(2, 1, FRAME_WAIT);

		foreach (seq_codes[i])
			change_mode(seq_codes[i]);

		bounce(CODE_SVGA, CODE_VGA);
		change_mode(CODE_SVGA); // Held code now takes effect

		$display("Errors: %0d in checks, %0d in measurements, %0d timeouts",
			chk_errs, meas_errs, tmo_errs);
		if (chk_errs == 0 && meas_errs == 0 && tmo_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tb.f
+incdir+tests
src/video_mode_pkg.sv
src/video_if.sv
src/switch_debouncer.sv
src/mode_table.sv
src/raster_counter.sv
src/sync_output.sv
src/video_timing_top.sv
tests/tb_video_timing.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video timing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_video_timing -f tb.f

out=$(./obj_dir/Vtb_video_timing)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
	exit 0
else
	exit 1
fi
